//--- list.f
+incdir+include
hdl/even_types_pkg.sv
hdl/even_stage_pkg.sv
hdl/even_decode.sv
hdl/fixed1_unit.sv
hdl/fixed2_unit.sv
hdl/byte_unit.sv
hdl/even_result.sv
hdl/even_pipe.sv
test/even_checker.sv
test/even_pipe_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the even pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module even_pipe_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/Veven_pipe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" sim.log; then
	exit 1
fi

exit 0

//--- test/even_pipe_tb.sv
`timescale 1ns/1ps
`include "even_params.svh"

module even_pipe_tb;

	typedef struct packed {
		even_types_pkg::raw_op_t op;
		even_types_pkg::reg_addr_t rt;
		logic wr;
		even_types_pkg::imm_t imm;
		int gap;	// Idle cycles before this issue
		logic match;	// ra_addr repeats the previous rt
		logic stall;
		logic rnd;
		even_types_pkg::reg_data_t ra;
		even_types_pkg::reg_data_t rb;
	} entry_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic issue;
	even_types_pkg::raw_op_t op;
	even_types_pkg::reg_addr_t rt_addr;
	even_types_pkg::reg_data_t ra;
	even_types_pkg::reg_data_t rb;
	even_types_pkg::reg_data_t rc;
	even_types_pkg::imm_t imm;
	logic reg_write;
	even_stage_pkg::src_addrs_t next_srcs;
	even_stage_pkg::result_t wb;
	even_stage_pkg::result_t [`EVEN_STAGES:1] fwd;
	logic stall_raw;
	logic exp_stall;

	entry_t tests[$];
	logic [31:0] rng_state = 32'd37;
	logic timed_out = 1'b0;

	always #20 clk = ~clk;

	even_pipe UUT (.clk(clk), .reset(reset), .issue(issue), .op(op), .rt_addr(rt_addr),
		.ra(ra), .rb(rb), .rc(rc), .imm(imm), .reg_write(reg_write), .next_srcs(next_srcs),
		.wb(wb), .fwd(fwd), .stall_raw(stall_raw));

	even_checker u_checker (.clk(clk), .reset(reset), .wb(wb), .fwd(fwd),
		.stall_raw(stall_raw), .exp_stall(exp_stall));

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic even_types_pkg::reg_data_t rand_data();
		even_types_pkg::reg_data_t d;
		for (int w = 0; w < 4; w++)
			d[w*32 +: 32] = xorshift32();
		return d;
	endfunction

	// Reference results straight from the instruction definitions
	function automatic even_types_pkg::reg_data_t model(even_types_pkg::raw_op_t o,
		even_types_pkg::reg_data_t a, even_types_pkg::reg_data_t b, even_types_pkg::imm_t i);
		even_types_pkg::reg_data_t r;
		logic [31:0] aw;
		logic [31:0] bw;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] ones;
		int avg;
		logic [4:0] sh;
		r = '0;
		for (int w = 0; w < 4; w++) begin
			aw = a[w*32 +: 32];
			bw = b[w*32 +: 32];
			sh = bw[4:0];
			case (o)
				even_types_pkg::opc_a: r[w*32 +: 32] = aw + bw;
				even_types_pkg::opc_ai: r[w*32 +: 32] = aw + {{22{i[9]}}, i};
				even_types_pkg::opc_and: r[w*32 +: 32] = aw & bw;
				even_types_pkg::opc_or: r[w*32 +: 32] = aw | bw;
				even_types_pkg::opc_xor: r[w*32 +: 32] = aw ^ bw;
				even_types_pkg::opc_shl: r[w*32 +: 32] = (bw[5:0] >= 6'd32) ? 32'd0 : aw << sh;
				even_types_pkg::opc_rotl:
					r[w*32 +: 32] = (sh == 5'd0) ? aw : (aw << sh) | (aw >> (6'd32 - sh));
				default: ;
			endcase
		end
		for (int k = 0; k < 16; k++) begin
			x = a[k*8 +: 8];
			y = b[k*8 +: 8];
			ones = 8'd0;
			for (int n = 0; n < 8; n++)
				ones = ones + {7'd0, x[n]};
			avg = (int'(x) + int'(y) + 1) / 2;
			case (o)
				even_types_pkg::opc_cntb: r[k*8 +: 8] = ones;
				even_types_pkg::opc_absdb: r[k*8 +: 8] = (x >= y) ? x - y : y - x;
				even_types_pkg::opc_avgb: r[k*8 +: 8] = avg[7:0];
				default: ;
			endcase
		end
		return r;
	endfunction

	// Chain slot a result enters, zero for codes the pipe does not execute
	function automatic int entry_slot(even_types_pkg::raw_op_t o);
		case (o)
			even_types_pkg::opc_a, even_types_pkg::opc_ai, even_types_pkg::opc_and,
			even_types_pkg::opc_or, even_types_pkg::opc_xor:
				return `EVEN_FX1_LAT;
			even_types_pkg::opc_shl, even_types_pkg::opc_rotl, even_types_pkg::opc_cntb,
			even_types_pkg::opc_absdb, even_types_pkg::opc_avgb:
				return `EVEN_FX2_LAT;
			default:
				return 0;
		endcase
	endfunction

	task automatic add_entry(even_types_pkg::raw_op_t o, int rt, logic wr, int i, int gap,
		logic match, logic stall, even_types_pkg::reg_data_t a, even_types_pkg::reg_data_t b);
		entry_t e;
		e.op = o;
		e.rt = rt[6:0];
		e.wr = wr;
		e.imm = i[9:0];
		e.gap = gap;
		e.match = match;
		e.stall = stall;
		e.rnd = (a == '0 && b == '0);	// Zero operands ask for random ones
		e.ra = a;
		e.rb = b;
		tests.push_back(e);
	endtask

	task automatic drive_idle();
		issue = 1'b0;
		reg_write = 1'b0;
		op = '0;
		next_srcs = {7'h70, 7'h71, 7'h72};	// Never used as a destination
		exp_stall = 1'b0;
	endtask

	task automatic build_table();
		add_entry(even_types_pkg::opc_a, 1, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_ai, 2, 1, -16, 0, 1, 1, '0, '0);
		add_entry(even_types_pkg::opc_and, 3, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_or, 4, 1, 0, 1, 1, 1, '0, '0);
		add_entry(even_types_pkg::opc_xor, 5, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_shl, 6, 1, 0, 0, 0, 0,
			128'h80000001_12345678_ffffffff_0000abcd, {32'd45, 32'd32, 32'd31, 32'd0});
		add_entry(even_types_pkg::opc_rotl, 7, 1, 0, 0, 1, 1,
			128'h80000001_12345678_ffffffff_0000abcd, {32'd45, 32'd32, 32'd31, 32'd0});
		add_entry(even_types_pkg::opc_a, 8, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_cntb, 9, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_ai, 10, 1, 5, 0, 1, 1, '0, '0);
		add_entry(even_types_pkg::opc_absdb, 11, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_avgb, 12, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_avgb, 13, 1, 0, 0, 0, 0,
			128'hff00ff01_7f80fe02_01020304_ffffffff, 128'h00ff0001_80800103_04030201_ff00fe01);
		add_entry(even_types_pkg::opc_a, 0, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_xor, 14, 1, 0, 0, 1, 0, '0, '0);
		add_entry(even_types_pkg::opc_shl, 15, 0, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_a, 16, 1, 0, 0, 1, 0, '0, '0);
		add_entry(11'h7ff, 17, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_or, 18, 1, 0, 0, 1, 0, '0, '0);
		add_entry(even_types_pkg::opc_cntb, 19, 1, 0, 6, 1, 1, '0, '0);
		add_entry(even_types_pkg::opc_and, 20, 1, 0, 7, 1, 0, '0, '0);
		add_entry(even_types_pkg::opc_rotl, 21, 1, 0, 0, 0, 0, '0, '0);
		add_entry(even_types_pkg::opc_a, 22, 1, 0, 0, 0, 0, '0, '0);
	endtask

	initial begin
		entry_t e;
		int wait_cnt;
		int slot;
		drive_idle();
		rt_addr = '0;
		ra = '0;
		rb = '0;
		rc = '0;
		imm = '0;
		build_table();
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		foreach (tests[i]) begin
			e = tests[i];
			for (int g = 0; g < e.gap; g++) begin
				drive_idle();
				@(posedge clk);
				#2;
			end
			if (e.rnd) begin
				e.ra = rand_data();
				e.rb = rand_data();
			end
			issue = 1'b1;
			op = e.op;
			rt_addr = e.rt;
			reg_write = e.wr;
			ra = e.ra;
			rb = e.rb;
			rc = rand_data();
			imm = e.imm;
			next_srcs = {(e.match && i > 0) ? tests[i-1].rt : 7'h70, 7'h71, 7'h72};
			exp_stall = e.stall;
			slot = entry_slot(e.op);
			u_checker.expect_wb(u_checker.cycle + 1, i, model(e.op, e.ra, e.rb, e.imm), e.rt,
				e.wr && slot != 0, slot);
			@(posedge clk);
			#2;
		end
		drive_idle();
		wait_cnt = 0;
		while (u_checker.pending() != 0 && wait_cnt < 50) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (u_checker.pending() != 0) begin
			timed_out = 1'b1;
			$display("timed out waiting for results to reach write-back");
		end
		@(posedge clk);
		$display("%0d tests, %0d errors", u_checker.tests, u_checker.errors);
		if (!timed_out && u_checker.errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- test/even_checker.sv
`timescale 1ns/1ps
`include "even_params.svh"

module even_checker (
	input logic clk,
	input logic reset,
	input even_stage_pkg::result_t wb,
	input even_stage_pkg::result_t [`EVEN_STAGES:1] fwd,
	input logic stall_raw,
	input logic exp_stall
);

	typedef struct packed {
		int tag;	// Edge at which the instruction was issued
		int idx;
		even_types_pkg::reg_data_t data;
		even_types_pkg::reg_addr_t rt;
		logic write;
		int slot;	// First chain slot the result enters
	} exp_t;

	exp_t exp_q[$];
	int cycle = 0;
	int errors = 0;
	int tests = 0;
	int test_err[int];

	always @(posedge clk) cycle <= cycle + 1;

	function automatic void expect_wb(int tag, int idx, even_types_pkg::reg_data_t data,
		even_types_pkg::reg_addr_t rt, logic write, int slot);
		exp_t e;
		e.tag = tag;
		e.idx = idx;
		e.data = data;
		e.rt = rt;
		e.write = write;
		e.slot = slot;
		exp_q.push_back(e);
		test_err[idx] = 0;
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic note_error(int idx);
		errors++;
		if (idx >= 0)
			test_err[idx] = test_err[idx] + 1;
	endtask

	task automatic check_taps();
		int d;
		logic [`EVEN_STAGES:1] busy;
		busy = '0;
		foreach (exp_q[i]) begin
			d = cycle - exp_q[i].tag;
			if (exp_q[i].write && d >= exp_q[i].slot && d <= `EVEN_STAGES) begin
				busy[d] = 1'b1;
				if (fwd[d].write !== 1'b1 || fwd[d].rt !== exp_q[i].rt ||
					fwd[d].data !== exp_q[i].data) begin
					$display("error fwd[%0d]: got %h/%h expected %h/%h (test %0d)", d,
						fwd[d].rt, fwd[d].data, exp_q[i].rt, exp_q[i].data, exp_q[i].idx);
					note_error(exp_q[i].idx);
				end
			end
		end
		// Slots without a writer in flight must be empty
		for (int k = 1; k <= `EVEN_STAGES; k++) begin
			if (!busy[k] && fwd[k].write !== 1'b0) begin
				$display("error fwd[%0d].write: got %h expected 0", k, fwd[k].write);
				note_error(-1);
			end
		end
	endtask

	task automatic check_wb();
		exp_t e;
		if (exp_q.size() > 0 && exp_q[0].tag + 7 == cycle) begin
			e = exp_q.pop_front();
			tests++;
			if (wb.write !== e.write) begin
				$display("error wb.write: got %h expected %h (test %0d)", wb.write, e.write, e.idx);
				note_error(e.idx);
			end
			else if (e.write) begin
				if (wb.rt !== e.rt) begin
					$display("error wb.rt: got %h expected %h (test %0d)", wb.rt, e.rt,
						e.idx);
					note_error(e.idx);
				end
				if (wb.data !== e.data) begin
					$display("error wb.data: got %h expected %h (test %0d)", wb.data,
						e.data, e.idx);
					note_error(e.idx);
				end
			end
			if (test_err[e.idx] == 0)
				$display("test %0d ok", e.idx);
			else
				$display("test %0d failed", e.idx);
		end
		else if (wb.write !== 1'b0) begin
			$display("error wb.write: got %h expected 0 with nothing due", wb.write);
			note_error(-1);
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (stall_raw !== exp_stall) begin	// Inputs settled since 2 ns after the edge
				$display("error stall_raw: got %h expected %h (cycle %0d)", stall_raw,
					exp_stall, cycle);
				note_error(-1);
			end
			check_taps();
			check_wb();
		end
	end

endmodule

//--- hdl/even_pipe.sv
`timescale 1ns/1ps
`include "even_params.svh"

module even_pipe (
	input logic clk,
	input logic reset,
	input logic issue,
	input even_types_pkg::raw_op_t op,
	input even_types_pkg::reg_addr_t rt_addr,
	input even_types_pkg::reg_data_t ra,
	input even_types_pkg::reg_data_t rb,
	input even_types_pkg::reg_data_t rc,	// Third operand, no even op here reads it
	input even_types_pkg::imm_t imm,
	input logic reg_write,
	input even_stage_pkg::src_addrs_t next_srcs,
	output even_stage_pkg::result_t wb,
	output even_stage_pkg::result_t [`EVEN_STAGES:1] fwd,
	output logic stall_raw
);

	even_stage_pkg::issue_t fx1_issue;
	even_stage_pkg::issue_t fx2_issue;
	even_stage_pkg::issue_t byte_issue;
	even_stage_pkg::result_t fx1_res;
	even_stage_pkg::result_t fx2_res;
	even_stage_pkg::result_t byte_res;
	logic [2:0] unit_hazard;	// fixed1, fixed2, byte

	even_decode u_decode (.issue(issue), .op(op), .rt_addr(rt_addr), .reg_write(reg_write),
		.ra(ra), .rb(rb), .imm(imm), .fx1_issue(fx1_issue), .fx2_issue(fx2_issue),
		.byte_issue(byte_issue));

	fixed1_unit u_fx1 (.clk(clk), .reset(reset), .in_issue(fx1_issue), .srcs(next_srcs),
		.res(fx1_res), .hazard(unit_hazard[0]));

	fixed2_unit u_fx2 (.clk(clk), .reset(reset), .in_issue(fx2_issue), .srcs(next_srcs),
		.res(fx2_res), .hazard(unit_hazard[1]));

	byte_unit u_byte (.clk(clk), .reset(reset), .in_issue(byte_issue), .srcs(next_srcs),
		.res(byte_res), .hazard(unit_hazard[2]));

	even_result u_result (.clk(clk), .reset(reset), .fx1_res(fx1_res), .fx2_res(fx2_res),
		.byte_res(byte_res), .unit_hazard(unit_hazard), .srcs(next_srcs), .wb(wb),
		.fwd(fwd), .stall_raw(stall_raw));

endmodule

//--- hdl/even_result.sv
`timescale 1ns/1ps
`include "even_params.svh"

module even_result (
	input logic clk,
	input logic reset,
	input even_stage_pkg::result_t fx1_res,
	input even_stage_pkg::result_t fx2_res,
	input even_stage_pkg::result_t byte_res,
	input logic [2:0] unit_hazard,
	input even_stage_pkg::src_addrs_t srcs,
	output even_stage_pkg::result_t wb,
	output even_stage_pkg::result_t [`EVEN_STAGES:1] fwd,
	output logic stall_raw
);

	localparam int FX1_SLOT = `EVEN_FX1_LAT;	// Slot that a fixed1 result enters
	localparam int FX2_SLOT = `EVEN_FX2_LAT;	// Shared by fixed2 and byte

	even_stage_pkg::result_t [`EVEN_STAGES:1] nxt;
	logic slot_hit;

	// Next chain contents, units overwrite their own slot
	always_comb begin
		nxt[1] = '0;		// Nothing enters at the head
		for (int k = 2; k <= `EVEN_STAGES; k++) begin
			nxt[k] = fwd[k-1];
		end
		if (fx1_res.write) begin
			nxt[FX1_SLOT] = fx1_res;
		end
		if (fx2_res.write) begin
			nxt[FX2_SLOT] = fx2_res;
		end
		else if (byte_res.write) begin
			nxt[FX2_SLOT] = byte_res;
		end
	end

	always_ff @(posedge clk) begin
		fwd <= nxt;
		wb <= fwd[`EVEN_STAGES];	// Last slot retires
		if (reset) begin
			for (int k = 1; k <= `EVEN_STAGES; k++) begin
				fwd[k].write <= 1'b0;
			end
			wb.write <= 1'b0;
		end
	end

	// Writers still in the chain, write-back itself no longer counts
	always_comb begin
		slot_hit = 1'b0;
		for (int k = 1; k <= `EVEN_STAGES; k++) begin
			slot_hit = slot_hit || even_stage_pkg::src_hit(srcs, fwd[k].rt, fwd[k].write);
		end
	end

	assign stall_raw = slot_hit || (|unit_hazard);

	a_one_slot4_writer: assert property (@(posedge clk) disable iff (reset)
		!(fx2_res.write && byte_res.write));

endmodule

//--- hdl/byte_unit.sv
`timescale 1ns/1ps
`include "even_params.svh"

module byte_unit (
	input logic clk,
	input logic reset,
	input even_stage_pkg::issue_t in_issue,
	input even_stage_pkg::src_addrs_t srcs,
	output even_stage_pkg::result_t res,
	output logic hazard
);

	localparam int BYTES = `EVEN_DATA_W / 8;
	localparam int LAT = `EVEN_FX2_LAT;

	even_stage_pkg::issue_t s1;
	even_stage_pkg::result_t s1_res;
	even_stage_pkg::result_t [LAT:2] pipe;

	always_comb begin
		logic [7:0] x;
		logic [7:0] y;
		logic [8:0] sum;

		s1_res.rt = s1.rt;
		s1_res.write = s1.write;
		s1_res.data = '0;
		for (int b = 0; b < BYTES; b++) begin
			x = s1.ra[b*8 +: 8];
			y = s1.rb[b*8 +: 8];
			sum = {1'b0, x} + {1'b0, y} + 9'd1;	// Round half up
			case (s1.op)
				even_types_pkg::op_cntb: s1_res.data[b*8 +: 8] = 8'($countones(x));
				even_types_pkg::op_absdb: s1_res.data[b*8 +: 8] = (x > y) ? x - y : y - x;
				even_types_pkg::op_avgb: s1_res.data[b*8 +: 8] = sum[8:1];
				default: s1_res.data[b*8 +: 8] = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		s1 <= in_issue;
		pipe[2] <= s1_res;
		for (int k = 3; k <= LAT; k++) begin
			pipe[k] <= pipe[k-1];
		end
		if (reset) begin
			s1.write <= 1'b0;
			for (int k = 2; k <= LAT; k++) begin
				pipe[k].write <= 1'b0;
			end
		end
	end

	assign res = pipe[LAT];

	// Same depth as fixed2, so both land in slot 4
	always_comb begin
		hazard = even_stage_pkg::src_hit(srcs, s1.rt, s1.write);
		for (int k = 2; k <= LAT; k++) begin
			hazard = hazard || even_stage_pkg::src_hit(srcs, pipe[k].rt, pipe[k].write);
		end
	end

endmodule

//--- hdl/fixed2_unit.sv
`timescale 1ns/1ps
`include "even_params.svh"

module fixed2_unit (
	input logic clk,
	input logic reset,
	input even_stage_pkg::issue_t in_issue,
	input even_stage_pkg::src_addrs_t srcs,
	output even_stage_pkg::result_t res,
	output logic hazard
);

	localparam int WORD_W = 32;
	localparam int WORDS = `EVEN_DATA_W / WORD_W;
	localparam int LAT = `EVEN_FX2_LAT;

	even_stage_pkg::issue_t s1;
	even_stage_pkg::result_t s1_res;
	even_stage_pkg::result_t [LAT:2] pipe;	// Delay stages up to slot 4

	always_comb begin
		logic [WORD_W-1:0] a;
		logic [5:0] cnt;
		logic [2*WORD_W-1:0] dbl;

		s1_res.rt = s1.rt;
		s1_res.write = s1.write;
		s1_res.data = '0;
		for (int w = 0; w < WORDS; w++) begin
			a = s1.ra[w*WORD_W +: WORD_W];
			cnt = s1.rb[w*WORD_W +: 6];
			dbl = {a, a} << cnt[4:0];	// Upper half is the rotated word
			case (s1.op)
				even_types_pkg::op_shl:
					s1_res.data[w*WORD_W +: WORD_W] = cnt[5] ? '0 : a << cnt[4:0];
				even_types_pkg::op_rotl:
					s1_res.data[w*WORD_W +: WORD_W] = dbl[2*WORD_W-1:WORD_W];
				default: s1_res.data[w*WORD_W +: WORD_W] = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		s1 <= in_issue;
		pipe[2] <= s1_res;
		for (int k = 3; k <= LAT; k++) begin
			pipe[k] <= pipe[k-1];
		end
		if (reset) begin
			s1.write <= 1'b0;
			for (int k = 2; k <= LAT; k++) begin
				pipe[k].write <= 1'b0;
			end
		end
	end

	assign res = pipe[LAT];

	always_comb begin
		hazard = even_stage_pkg::src_hit(srcs, s1.rt, s1.write);
		for (int k = 2; k <= LAT; k++) begin
			hazard = hazard || even_stage_pkg::src_hit(srcs, pipe[k].rt, pipe[k].write);
		end
	end

endmodule

//--- hdl/fixed1_unit.sv
`timescale 1ns/1ps
`include "even_params.svh"

module fixed1_unit (
	input logic clk,
	input logic reset,
	input even_stage_pkg::issue_t in_issue,
	input even_stage_pkg::src_addrs_t srcs,
	output even_stage_pkg::result_t res,
	output logic hazard
);

	localparam int WORD_W = 32;
	localparam int WORDS = `EVEN_DATA_W / WORD_W;

	even_stage_pkg::issue_t s1;
	even_stage_pkg::result_t s1_res;

	always_comb begin
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [WORD_W-1:0] sext;

		s1_res.rt = s1.rt;
		s1_res.write = s1.write;
		s1_res.data = '0;
		sext = {{(WORD_W-`EVEN_IMM_W){s1.imm[`EVEN_IMM_W-1]}}, s1.imm};
		for (int w = 0; w < WORDS; w++) begin
			a = s1.ra[w*WORD_W +: WORD_W];
			b = s1.rb[w*WORD_W +: WORD_W];
			case (s1.op)
				even_types_pkg::op_a: s1_res.data[w*WORD_W +: WORD_W] = a + b;
				even_types_pkg::op_ai: s1_res.data[w*WORD_W +: WORD_W] = a + sext;
				even_types_pkg::op_and: s1_res.data[w*WORD_W +: WORD_W] = a & b;
				even_types_pkg::op_or: s1_res.data[w*WORD_W +: WORD_W] = a | b;
				even_types_pkg::op_xor: s1_res.data[w*WORD_W +: WORD_W] = a ^ b;
				default: s1_res.data[w*WORD_W +: WORD_W] = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		s1 <= in_issue;		// Operand capture
		res <= s1_res;		// Result register feeds slot 2
		if (reset) begin
			s1.write <= 1'b0;
			res.write <= 1'b0;
		end
	end

	assign hazard = even_stage_pkg::src_hit(srcs, s1.rt, s1.write) ||
		even_stage_pkg::src_hit(srcs, res.rt, res.write);

	// Only word arithmetic and logic may be steered here
	a_fx1_op: assert property (@(posedge clk) disable iff (reset)
		in_issue.write |-> in_issue.op inside {even_types_pkg::op_a, even_types_pkg::op_ai,
			even_types_pkg::op_and, even_types_pkg::op_or, even_types_pkg::op_xor});

endmodule

//--- hdl/even_decode.sv
`timescale 1ns/1ps

module even_decode (
	input logic issue,
	input even_types_pkg::raw_op_t op,
	input even_types_pkg::reg_addr_t rt_addr,
	input logic reg_write,
	input even_types_pkg::reg_data_t ra,
	input even_types_pkg::reg_data_t rb,
	input even_types_pkg::imm_t imm,
	output even_stage_pkg::issue_t fx1_issue,
	output even_stage_pkg::issue_t fx2_issue,
	output even_stage_pkg::issue_t byte_issue
);

	even_types_pkg::unit_e unit;
	even_types_pkg::alu_op_e alu_op;
	logic wr;
	even_stage_pkg::issue_t base;

	always_comb begin
		unit = even_types_pkg::unit_none;	// Unknown codes become bubbles
		alu_op = even_types_pkg::op_a;
		case (op)
			even_types_pkg::opc_a: begin
				unit = even_types_pkg::unit_fx1;
				alu_op = even_types_pkg::op_a;
			end
			even_types_pkg::opc_ai: begin
				unit = even_types_pkg::unit_fx1;
				alu_op = even_types_pkg::op_ai;
			end
			even_types_pkg::opc_and: begin
				unit = even_types_pkg::unit_fx1;
				alu_op = even_types_pkg::op_and;
			end
			even_types_pkg::opc_or: begin
				unit = even_types_pkg::unit_fx1;
				alu_op = even_types_pkg::op_or;
			end
			even_types_pkg::opc_xor: begin
				unit = even_types_pkg::unit_fx1;
				alu_op = even_types_pkg::op_xor;
			end
			even_types_pkg::opc_shl: begin
				unit = even_types_pkg::unit_fx2;
				alu_op = even_types_pkg::op_shl;
			end
			even_types_pkg::opc_rotl: begin
				unit = even_types_pkg::unit_fx2;
				alu_op = even_types_pkg::op_rotl;
			end
			even_types_pkg::opc_cntb: begin
				unit = even_types_pkg::unit_byte;
				alu_op = even_types_pkg::op_cntb;
			end
			even_types_pkg::opc_absdb: begin
				unit = even_types_pkg::unit_byte;
				alu_op = even_types_pkg::op_absdb;
			end
			even_types_pkg::opc_avgb: begin
				unit = even_types_pkg::unit_byte;
				alu_op = even_types_pkg::op_avgb;
			end
			default: ;
		endcase
	end

	assign wr = issue && reg_write && (unit != even_types_pkg::unit_none);

	always_comb begin
		base.op = alu_op;
		base.rt = rt_addr;
		base.write = 1'b0;
		base.ra = ra;
		base.rb = rb;
		base.imm = imm;

		fx1_issue = base;
		fx2_issue = base;
		byte_issue = base;
		fx1_issue.write = wr && (unit == even_types_pkg::unit_fx1);	// Steer to one unit
		fx2_issue.write = wr && (unit == even_types_pkg::unit_fx2);
		byte_issue.write = wr && (unit == even_types_pkg::unit_byte);
	end

endmodule

//--- hdl/even_stage_pkg.sv
package even_stage_pkg;

	// Record handed from decode to one unit
	typedef struct packed {
		even_types_pkg::alu_op_e op;
		even_types_pkg::reg_addr_t rt;
		logic write;
		even_types_pkg::reg_data_t ra;
		even_types_pkg::reg_data_t rb;
		even_types_pkg::imm_t imm;
	} issue_t;

	// Unit output and staging slot contents
	typedef struct packed {
		even_types_pkg::reg_data_t data;
		even_types_pkg::reg_addr_t rt;
		logic write;
	} result_t;

	typedef struct packed {
		even_types_pkg::reg_addr_t ra_addr;
		even_types_pkg::reg_addr_t rb_addr;
		even_types_pkg::reg_addr_t rc_addr;
	} src_addrs_t;

	// True when an in-flight writer to rt feeds one of the next sources
	function automatic logic src_hit(src_addrs_t s, even_types_pkg::reg_addr_t rt, logic wr);
		return wr && (rt != '0) &&
			(s.ra_addr == rt || s.rb_addr == rt || s.rc_addr == rt);	// r0 never stalls
	endfunction

endpackage

//--- hdl/even_types_pkg.sv
`include "even_params.svh"

package even_types_pkg;

	typedef logic [`EVEN_DATA_W-1:0] reg_data_t;	// Four words or sixteen bytes
	typedef logic [`EVEN_ADDR_W-1:0] reg_addr_t;
	typedef logic [`EVEN_OP_W-1:0] raw_op_t;
	typedef logic [`EVEN_IMM_W-1:0] imm_t;		// Signed, extended in the unit

	typedef enum logic [1:0] {
		unit_none,
		unit_fx1,
		unit_fx2,
		unit_byte
	} unit_e;

	typedef enum logic [3:0] {
		op_a,
		op_ai,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_rotl,
		op_cntb,
		op_absdb,
		op_avgb
	} alu_op_e;

	// Raw opcodes, RI10 forms padded with zeros to 11 bits
	localparam raw_op_t opc_a = 11'b00011000000;
	localparam raw_op_t opc_ai = 11'b00011100000;
	localparam raw_op_t opc_and = 11'b00011000001;
	localparam raw_op_t opc_or = 11'b00001000001;
	localparam raw_op_t opc_xor = 11'b01001000001;
	localparam raw_op_t opc_shl = 11'b00001011011;
	localparam raw_op_t opc_rotl = 11'b00001011000;
	localparam raw_op_t opc_cntb = 11'b01010110100;
	localparam raw_op_t opc_absdb = 11'b00001010011;
	localparam raw_op_t opc_avgb = 11'b00011010011;

endpackage

//--- include/even_params.svh
`ifndef EVEN_PARAMS_SVH
`define EVEN_PARAMS_SVH

// Datapath widths
`define EVEN_DATA_W 128
`define EVEN_ADDR_W 7
`define EVEN_OP_W 11
`define EVEN_IMM_W 10

// Unit latencies in cycles from issue to the unit result register
`define EVEN_FX1_LAT 2
`define EVEN_FX2_LAT 4

// Staging chain slots 1..6, write-back is the register after slot 6
`define EVEN_STAGES 6

`endif
